// ==== verilog/fpu_consts.svh ====
// fpu constants
// exponent bias, float field widths, multiplier step count and the
// byte-bus register map of the coprocessor
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// single precision fields
`define FPU_EXP_BIAS  127
`define FPU_EXP_W     8
`define FPU_MANT_W    23   // stored mantissa, hidden bit not included
`define FPU_SIG_W     24   // mantissa with hidden bit restored

// sequential multiplier, one add and one shift per step
`define FPU_MUL_STEPS 24

// register map, 32-bit registers take four byte addresses, little endian
`define FPU_ADDR_W    4
`define FPU_ADDR_A0   0
`define FPU_ADDR_B0   4
`define FPU_ADDR_OP   8    // single byte, low nibble is the opcode
`define FPU_ADDR_R0   9

`endif

// ==== verilog/fpu_pkg.sv ====
// fpu types
// operation codes, command controller states and the single precision
// float layout shared by the register file and both datapaths
`include "fpu_consts.svh"

package fpu_pkg;

  // opcode as written to the operation register
  typedef enum logic [3:0] {
    op_add = 4'd0,
    op_sub = 4'd1,   // add with sign of b inverted
    op_mul = 4'd2
  } e_fpu_op;

  // command controller states
  typedef enum logic [1:0] {
    idle_st,          // waiting for an operation write
    addsub_st,        // combinational path settles, result loaded here
    mul_run_st,       // shift-add multiplier running
    result_valid_st   // holds cmd_end until end_ack
  } e_fpu_state;

  typedef struct packed {
    logic                   sign;
    logic [`FPU_EXP_W-1:0]  exponent;   // biased
    logic [`FPU_MANT_W-1:0] mantissa;   // fraction, hidden bit implied
  } fp32_t;

endpackage

// ==== verilog/fpu_op_if.sv ====
// fpu operand interface
// operands and opcode from the register file to the datapaths, plus the
// pending/taken handshake between register file and controller
`timescale 1ns/1ps

interface fpu_op_if;

  fpu_pkg::fp32_t   operand_a;
  fpu_pkg::fp32_t   operand_b;
  fpu_pkg::e_fpu_op operation;
  logic             op_pending;  // valid opcode written, not yet taken
  logic             op_taken;    // one cycle pulse from the controller

  modport regs_mp (
    output operand_a, operand_b, operation, op_pending,
    input  op_taken
  );

  modport ctrl_mp (
    input  operation, op_pending,
    output op_taken
  );

  modport unit_mp (
    input operand_a, operand_b, operation
  );

endinterface

// ==== verilog/fpu_regs.sv ====
// fpu register file
// byte-wide bus access to operands a and b, the opcode and the result,
// writes sampled on clk and locked out while the unit is busy
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpu_regs (
  input  logic             clk,
  input  logic             arst,
  input  logic [7:0]       data_in,
  output logic [7:0]       data_out,
  input  logic [3:0]       addr,
  input  logic             cs,
  input  logic             rd,
  input  logic             wr,
  input  logic             busy,
  fpu_op_if.regs_mp        op,
  input  logic             result_load,
  input  fpu_pkg::fp32_t   addsub_result,
  input  fpu_pkg::fp32_t   mul_result
);

  logic [31:0]             a_q, b_q, res_q;
  fpu_pkg::e_fpu_op        op_q;
  logic                    pending_q;
  logic                    wr_en;
  logic [`FPU_ADDR_W-1:0]  a_off, b_off, r_off;   // byte lane within each register
  logic                    sel_a, sel_b, sel_op, sel_r;

  assign a_off  = addr - `FPU_ADDR_W'(`FPU_ADDR_A0);
  assign b_off  = addr - `FPU_ADDR_W'(`FPU_ADDR_B0);
  assign r_off  = addr - `FPU_ADDR_W'(`FPU_ADDR_R0);
  assign sel_a  = (a_off < 4);   // wraps above 15 for addresses below the base
  assign sel_b  = (b_off < 4);
  assign sel_r  = (r_off < 4);
  assign sel_op = (addr == `FPU_ADDR_W'(`FPU_ADDR_OP));

  assign wr_en  = !cs && !wr && !busy;   // bus is active low, locked during a command

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      a_q       <= '0;
      b_q       <= '0;
      res_q     <= '0;
      op_q      <= fpu_pkg::op_add;
      pending_q <= 1'b0;
    end else begin
      if (op.op_taken) pending_q <= 1'b0;
      if (wr_en) begin
        if (sel_a) a_q[{a_off[1:0], 3'b000} +: 8] <= data_in;
        if (sel_b) b_q[{b_off[1:0], 3'b000} +: 8] <= data_in;
        if (sel_op) begin
          case (fpu_pkg::e_fpu_op'(data_in[3:0]))
            fpu_pkg::op_add, fpu_pkg::op_sub, fpu_pkg::op_mul: begin
              op_q      <= fpu_pkg::e_fpu_op'(data_in[3:0]);
              pending_q <= 1'b1;   // kicks the controller
            end
            default: ;             // unknown codes leave everything as is
          endcase
        end
      end
      // result source follows the stored opcode
      if (result_load) res_q <= (op_q == fpu_pkg::op_mul) ? mul_result : addsub_result;
    end
  end

  assign op.operand_a  = a_q;
  assign op.operand_b  = b_q;
  assign op.operation  = op_q;
  assign op.op_pending = pending_q;

  // read mux, zero when not selected or unmapped
  always_comb begin
    data_out = '0;
    if (!cs && !rd) begin
      if (sel_a)       data_out = a_q[{a_off[1:0], 3'b000} +: 8];
      else if (sel_b)  data_out = b_q[{b_off[1:0], 3'b000} +: 8];
      else if (sel_op) data_out = {4'b0000, op_q};
      else if (sel_r)  data_out = res_q[{r_off[1:0], 3'b000} +: 8];
    end
  end

endmodule

// ==== verilog/fpu_ctrl.sv ====
// fpu command controller
// dispatches a pending opcode to the add/sub path or the multiplier,
// loads the result and holds cmd_end until the host acknowledges
`timescale 1ns/1ps

module fpu_ctrl (
  input  logic       clk,
  input  logic       arst,
  fpu_op_if.ctrl_mp  op,
  input  logic       end_ack,
  input  logic       mul_done,
  output logic       mul_start,
  output logic       result_load,
  output logic       busy,
  output logic       cmd_end
);

  fpu_pkg::e_fpu_state state, state_nxt;
  logic                op_taken_q;

  always_comb begin
    state_nxt = state;
    case (state)
      fpu_pkg::idle_st:
        if (op.op_pending) begin
          case (op.operation)
            fpu_pkg::op_add, fpu_pkg::op_sub: state_nxt = fpu_pkg::addsub_st;
            fpu_pkg::op_mul:                  state_nxt = fpu_pkg::mul_run_st;
            default:                          state_nxt = fpu_pkg::idle_st;
          endcase
        end
      fpu_pkg::addsub_st:
        state_nxt = fpu_pkg::result_valid_st;   // result_load is high this cycle
      fpu_pkg::mul_run_st:
        if (result_load) state_nxt = fpu_pkg::result_valid_st;  // one cycle after mul_done
      fpu_pkg::result_valid_st:
        if (end_ack) state_nxt = fpu_pkg::idle_st;
      default:
        state_nxt = fpu_pkg::idle_st;
    endcase
  end

  // outputs registered from the next state
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state       <= fpu_pkg::idle_st;
      op_taken_q  <= 1'b0;
      mul_start   <= 1'b0;
      result_load <= 1'b0;
      busy        <= 1'b0;
      cmd_end     <= 1'b0;
    end else begin
      state       <= state_nxt;
      op_taken_q  <= (state == fpu_pkg::idle_st) && (state_nxt != fpu_pkg::idle_st);
      mul_start   <= (state == fpu_pkg::idle_st) && (state_nxt == fpu_pkg::mul_run_st);
      // load lands on the same edge that raises cmd_end
      result_load <= ((state == fpu_pkg::idle_st) && (state_nxt == fpu_pkg::addsub_st)) ||
                     ((state == fpu_pkg::mul_run_st) && mul_done);
      busy        <= (state_nxt != fpu_pkg::idle_st);
      cmd_end     <= (state_nxt == fpu_pkg::result_valid_st);
    end
  end

  assign op.op_taken = op_taken_q;   // clears the pending flag in the register file

endmodule

// ==== verilog/fpu_addsub.sv ====
// fpu add/sub datapath
// combinational exponent align, two's complement add and normalize,
// truncating, no rounding and no special values
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpu_addsub (
  fpu_op_if.unit_mp       op,
  output fpu_pkg::fp32_t  addsub_result
);

  logic [`FPU_SIG_W-1:0]        sig_a, sig_b;     // hidden bit restored
  logic [`FPU_SIG_W-1:0]        al_a, al_b;       // after alignment
  logic [`FPU_EXP_W-1:0]        exp_big, exp_diff, exp_norm;
  logic                         sign_b;
  logic signed [`FPU_SIG_W+1:0] val_a, val_b, sum;
  logic [`FPU_SIG_W:0]          mag, mag_norm;

  assign sig_a  = {1'b1, op.operand_a.mantissa};
  assign sig_b  = {1'b1, op.operand_b.mantissa};
  assign sign_b = op.operand_b.sign ^ (op.operation == fpu_pkg::op_sub);  // sub flips b

  // shift the smaller operand right, 25 or more places leaves zero
  always_comb begin
    if (op.operand_a.exponent >= op.operand_b.exponent) begin
      exp_big  = op.operand_a.exponent;
      exp_diff = op.operand_a.exponent - op.operand_b.exponent;
      al_a     = sig_a;
      al_b     = sig_b >> exp_diff;
    end else begin
      exp_big  = op.operand_b.exponent;
      exp_diff = op.operand_b.exponent - op.operand_a.exponent;
      al_a     = sig_a >> exp_diff;
      al_b     = sig_b;
    end
  end

  // signed magnitudes into two's complement, 26 bits never overflow
  assign val_a = op.operand_a.sign ? -signed'({2'b00, al_a}) : signed'({2'b00, al_a});
  assign val_b = sign_b            ? -signed'({2'b00, al_b}) : signed'({2'b00, al_b});
  assign sum   = val_a + val_b;

  always_comb begin
    mag      = sum[`FPU_SIG_W+1] ? (~sum[`FPU_SIG_W:0] + 1'b1) : sum[`FPU_SIG_W:0];
    mag_norm = mag;
    exp_norm = exp_big;
    if (mag[`FPU_SIG_W]) begin       // carry out, one step right
      mag_norm = mag >> 1;
      exp_norm = exp_big + 1'b1;
    end else begin
      // leading zero walk, fixed bound keeps it combinational
      for (int i = 0; i < `FPU_SIG_W - 1; i++) begin
        if (!mag_norm[`FPU_SIG_W-1]) begin
          mag_norm = mag_norm << 1;
          exp_norm = exp_norm - 1'b1;
        end
      end
    end
  end

  // exact cancellation gives +0
  assign addsub_result = (mag == '0) ? '0
                       : {sum[`FPU_SIG_W+1], exp_norm, mag_norm[`FPU_MANT_W-1:0]};

endmodule

// ==== verilog/fpu_mul.sv ====
// fpu multiplier datapath
// sequential shift-add mantissa multiply, one add and one shift cycle per
// step, exponent sum and sign xor formed from the final product
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpu_mul (
  input  logic            clk,
  input  logic            arst,
  fpu_op_if.unit_mp       op,
  input  logic            mul_start,
  output logic            mul_done,
  output fpu_pkg::fp32_t  mul_result
);

  logic [2*`FPU_SIG_W:0]   prod;       // upper half accumulates, lower half holds multiplier
  logic [4:0]              step_cnt;
  logic                    shift_ph;   // 0 add step, 1 shift step
  logic                    running;
  logic                    load;
  logic [`FPU_EXP_W+1:0]   exp_sum;    // room for the sum before bias removal

  assign load = mul_start && (op.operation == fpu_pkg::op_mul);

  // step sequencing
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      running  <= 1'b0;
      shift_ph <= 1'b0;
      step_cnt <= '0;
      mul_done <= 1'b0;
    end else begin
      mul_done <= 1'b0;
      if (load) begin
        running  <= 1'b1;
        shift_ph <= 1'b0;
        step_cnt <= '0;
      end else if (running) begin
        shift_ph <= ~shift_ph;
        if (shift_ph) begin
          step_cnt <= step_cnt + 5'd1;
          if (step_cnt == 5'(`FPU_MUL_STEPS - 1)) begin
            running  <= 1'b0;
            mul_done <= 1'b1;   // product is final from here on
          end
        end
      end
    end
  end

  // product/multiplier register
  always_ff @(posedge clk) begin
    if (load) begin
      prod <= {{(`FPU_SIG_W+1){1'b0}}, 1'b1, op.operand_b.mantissa};
    end else if (running) begin
      if (!shift_ph) begin
        if (prod[0])   // multiplier lsb set, add multiplicand on top, bit 48 catches the carry
          prod[2*`FPU_SIG_W:`FPU_SIG_W] <= prod[2*`FPU_SIG_W:`FPU_SIG_W] +
                                           {1'b0, 1'b1, op.operand_a.mantissa};
      end else begin
        prod <= prod >> 1;
      end
    end
  end

  // product bit 47 set means 1x.xxx, bump the exponent
  assign exp_sum = {2'b00, op.operand_a.exponent} + {2'b00, op.operand_b.exponent}
                 - 10'(`FPU_EXP_BIAS) + 10'(prod[47]);

  assign mul_result.sign     = op.operand_a.sign ^ op.operand_b.sign;
  assign mul_result.exponent = exp_sum[`FPU_EXP_W-1:0];
  assign mul_result.mantissa = prod[47] ? prod[46:24] : prod[45:23];   // truncated

endmodule

// ==== verilog/fpu_top.sv ====
// fpu coprocessor top
// byte bus register file, command controller and the add/sub and
// multiply datapaths, joined by the operand interface
`timescale 1ns/1ps

module fpu_top (
  input  logic       clk,
  input  logic       arst,
  input  logic [7:0] data_in,
  output logic [7:0] data_out,
  input  logic [3:0] addr,
  input  logic       cs,        // active low
  input  logic       rd,        // active low
  input  logic       wr,        // active low
  input  logic       end_ack,
  output logic       cmd_end,
  output logic       busy
);

  fpu_pkg::fp32_t addsub_result, mul_result;
  logic           mul_start, mul_done, result_load;

  fpu_op_if op_if ();

  fpu_regs regs_i (
    .clk           (clk),
    .arst          (arst),
    .data_in       (data_in),
    .data_out      (data_out),
    .addr          (addr),
    .cs            (cs),
    .rd            (rd),
    .wr            (wr),
    .busy          (busy),
    .op            (op_if.regs_mp),
    .result_load   (result_load),
    .addsub_result (addsub_result),
    .mul_result    (mul_result)
  );

  fpu_ctrl ctrl_i (
    .clk         (clk),
    .arst        (arst),
    .op          (op_if.ctrl_mp),
    .end_ack     (end_ack),
    .mul_done    (mul_done),
    .mul_start   (mul_start),
    .result_load (result_load),
    .busy        (busy),
    .cmd_end     (cmd_end)
  );

  fpu_addsub addsub_i (
    .op            (op_if.unit_mp),
    .addsub_result (addsub_result)
  );

  fpu_mul mul_i (
    .clk        (clk),
    .arst       (arst),
    .op         (op_if.unit_mp),
    .mul_start  (mul_start),
    .mul_done   (mul_done),
    .mul_result (mul_result)
  );

endmodule

// ==== dv/fpu_assert.sv ====
// fpu controller protocol checks
// bound into the command controller, watches the busy/cmd_end/end_ack
// handshake and the single cycle control pulses
`timescale 1ns/1ps

module fpu_assert (
  input logic                clk,
  input logic                arst,
  input logic                busy,
  input logic                cmd_end,
  input logic                mul_start,
  input logic                result_load,
  input logic                end_ack
);

  // result is only presented while a command holds the unit
  cmd_end_busy_a: assert property (@(posedge clk) disable iff (arst) cmd_end |-> busy)
    else $error("cmd_end high while busy is low");

  mul_start_pulse_a: assert property (@(posedge clk) disable iff (arst)
    mul_start |=> !mul_start)
    else $error("mul_start held for more than one cycle");

  result_load_pulse_a: assert property (@(posedge clk) disable iff (arst)
    result_load |=> !result_load)
    else $error("result_load held for more than one cycle");

  // release only through the host acknowledge
  busy_release_a: assert property (@(posedge clk) disable iff (arst)
    $fell(busy) |-> $past(end_ack))
    else $error("busy dropped without end_ack");

endmodule

// ==== dv/fpu_tb.sv ====
// fpu coprocessor testbench
// drives the byte bus, runs random add, sub and mul commands and checks
// every read-back against a float model of the truncating arithmetic
`timescale 1ns/1ps
`include "fpu_consts.svh"

module fpu_tb;

  localparam int cmd_timeout = 200;   // cycles, mul needs about 52
  localparam int ack_timeout = 10;

  logic       clk;
  logic       arst;
  logic [7:0] data_in;
  logic [7:0] data_out;
  logic [3:0] addr;
  logic       cs, rd, wr;
  logic       end_ack;
  logic       cmd_end, busy;

  logic [31:0] got_q[$];   // read-back words waiting for the compare process
  logic [31:0] exp_q[$];
  string       what_q[$];
  int          pushed;
  int          checked;

  fpu_top dut_i (
    .clk      (clk),
    .arst     (arst),
    .data_in  (data_in),
    .data_out (data_out),
    .addr     (addr),
    .cs       (cs),
    .rd       (rd),
    .wr       (wr),
    .end_ack  (end_ack),
    .cmd_end  (cmd_end),
    .busy     (busy)
  );

  bind fpu_ctrl fpu_assert assert_i (
    .clk         (clk),
    .arst        (arst),
    .busy        (busy),
    .cmd_end     (cmd_end),
    .mul_start   (mul_start),
    .result_load (result_load),
    .end_ack     (end_ack)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_on_fail();
    $display(">>> FAIL");
    $fatal(1, "stopped at first error");
  endtask

  // float model: align, signed add, normalize, truncating shift-add multiply
  function automatic fpu_pkg::fp32_t fpu_model(fpu_pkg::fp32_t a, fpu_pkg::fp32_t b,
                                               fpu_pkg::e_fpu_op code);
    longint         sig_a, sig_b, sum, mag, prod;
    int             exp_r, diff;
    logic           sign_b;
    fpu_pkg::fp32_t r;
    sig_a = {1'b1, a.mantissa};   // hidden bit back
    sig_b = {1'b1, b.mantissa};
    r     = '0;
    if (code == fpu_pkg::op_mul) begin
      prod  = sig_a * sig_b;
      exp_r = int'(a.exponent) + int'(b.exponent) - `FPU_EXP_BIAS;
      if (prod[47]) begin
        exp_r      = exp_r + 1;
        r.mantissa = prod[46:24];
      end else begin
        r.mantissa = prod[45:23];
      end
      r.sign     = a.sign ^ b.sign;
      r.exponent = exp_r[7:0];
      return r;
    end
    sign_b = b.sign ^ (code == fpu_pkg::op_sub);
    diff   = int'(a.exponent) - int'(b.exponent);
    if (diff >= 0) begin
      exp_r = a.exponent;
      sig_b = (diff > 24) ? 0 : sig_b >> diff;
    end else begin
      exp_r = b.exponent;
      sig_a = (-diff > 24) ? 0 : sig_a >> -diff;
    end
    sum = (a.sign ? -sig_a : sig_a) + (sign_b ? -sig_b : sig_b);
    if (sum == 0) return '0;   // exact cancellation
    r.sign = (sum < 0);
    mag    = (sum < 0) ? -sum : sum;
    if (mag[24]) begin
      mag   = mag >> 1;
      exp_r = exp_r + 1;
    end else begin
      while (!mag[23]) begin
        mag   = mag << 1;
        exp_r = exp_r - 1;
      end
    end
    r.exponent = exp_r[7:0];
    r.mantissa = mag[22:0];
    return r;
  endfunction

  function automatic fpu_pkg::fp32_t rand_operand();
    fpu_pkg::fp32_t f;
    f.sign     = 1'($urandom);
    f.exponent = 8'(100 + $urandom_range(50));   // keeps sums and products in range
    f.mantissa = 23'($urandom);
    return f;
  endfunction

  task automatic write_byte(input logic [3:0] a, input logic [7:0] d);
    @(posedge clk);
    addr    <= a;
    data_in <= d;
    cs      <= 1'b0;
    rd      <= 1'b1;
    wr      <= 1'b0;
    @(posedge clk);   // write lands on this edge
    cs <= 1'b1;
    wr <= 1'b1;
  endtask

  task automatic read_byte(input logic [3:0] a, output logic [7:0] d);
    @(posedge clk);
    addr <= a;
    cs   <= 1'b0;
    rd   <= 1'b0;
    wr   <= 1'b1;
    @(negedge clk);
    d = data_out;   // combinational read, settled mid cycle
  endtask

  task automatic write_word(input logic [3:0] base, input logic [31:0] w);
    for (int i = 0; i < 4; i++) write_byte(base + 4'(i), w[8*i +: 8]);   // little endian
  endtask

  task automatic read_word(input logic [3:0] base, output logic [31:0] w);
    logic [7:0] b;
    for (int i = 0; i < 4; i++) begin
      read_byte(base + 4'(i), b);
      w[8*i +: 8] = b;
    end
  endtask

  task automatic expect_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    got_q.push_back(got);
    exp_q.push_back(exp);
    what_q.push_back(what);
    pushed++;
  endtask

  // counts edges from the operation write until cmd_end is seen
  task automatic wait_cmd_end(input bit check_busy, output int cycles);
    cycles = 0;
    @(negedge clk);
    while (!cmd_end) begin
      if (check_busy) begin
        assert (busy) else begin
          $display("[FAIL] %0t ns: busy low while the multiply is running", $time);
          stop_on_fail();
        end
      end
      if (cycles >= cmd_timeout) begin
        $display("timed out waiting for cmd_end");
        stop_on_fail();
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic acknowledge();
    int cycles;
    cycles = 0;
    @(posedge clk);
    end_ack <= 1'b1;
    @(negedge clk);
    while (busy) begin
      if (cycles >= ack_timeout) begin
        $display("timed out waiting for busy to fall after end_ack");
        stop_on_fail();
      end
      @(negedge clk);
      cycles++;
    end
    assert (!cmd_end) else begin
      $display("[FAIL] %0t ns: cmd_end still high after end_ack", $time);
      stop_on_fail();
    end
    @(posedge clk);
    end_ack <= 1'b0;
  endtask

  task automatic run_command(input fpu_pkg::fp32_t a, input fpu_pkg::fp32_t b,
                             input fpu_pkg::e_fpu_op code);
    int          cycles;
    logic [31:0] got;
    logic [7:0]  op_byte;
    write_word(`FPU_ADDR_A0, a);
    write_word(`FPU_ADDR_B0, b);
    write_byte(`FPU_ADDR_OP, {4'h0, code});
    if (code == fpu_pkg::op_mul) begin
      write_word(`FPU_ADDR_A0, ~a);   // unit is busy, these writes must be dropped
      write_word(`FPU_ADDR_B0, ~b);
      wait_cmd_end(1'b1, cycles);
    end else begin
      wait_cmd_end(1'b0, cycles);
      assert (cycles == 2) else begin
        $display("[FAIL] %0t ns: cmd_end after %0d cycles, expected 2", $time, cycles);
        stop_on_fail();
      end
    end
    read_word(`FPU_ADDR_R0, got);
    expect_word(got, fpu_model(a, b, code), "result");
    read_byte(`FPU_ADDR_OP, op_byte);
    expect_word({24'h0, op_byte}, {28'h0, code}, "opcode");
    acknowledge();
    read_word(`FPU_ADDR_A0, got);
    expect_word(got, a, "operand a");
    read_word(`FPU_ADDR_B0, got);
    expect_word(got, b, "operand b");
  endtask

  // compares every queued read-back with its expected word
  always @(posedge clk) begin : compare_proc
    logic [31:0] got, exp;
    string       what;
    while (got_q.size() > 0) begin
      got  = got_q.pop_front();
      exp  = exp_q.pop_front();
      what = what_q.pop_front();
      checked++;
      assert (got == exp) else begin
        $display("[FAIL] %0t ns: %s read %08h, expected %08h", $time, what, got, exp);
        stop_on_fail();
      end
    end
  end

  initial begin : stimulus
    fpu_pkg::fp32_t a, b;
    logic [7:0]     d;
    logic [31:0]    w;
    int             drain;
    void'($urandom(32'hd5eb180f));
    arst    = 1'b1;
    cs      = 1'b1;
    rd      = 1'b1;
    wr      = 1'b1;
    addr    = '0;
    data_in = '0;
    end_ack = 1'b0;
    pushed  = 0;
    checked = 0;
    repeat (5) @(posedge clk);
    arst <= 1'b0;
    @(negedge clk);
    assert (!busy && !cmd_end) else begin
      $display("[FAIL] %0t ns: busy or cmd_end high after reset", $time);
      stop_on_fail();
    end
    for (int i = 0; i <= 12; i++) begin   // whole map reads zero out of reset
      read_byte(4'(i), d);
      expect_word({24'h0, d}, 32'h0, "reset value");
    end
    a = rand_operand();
    b = rand_operand();
    write_word(`FPU_ADDR_A0, a);
    write_word(`FPU_ADDR_B0, b);
    read_word(`FPU_ADDR_A0, w);
    expect_word(w, a, "operand a write");
    read_word(`FPU_ADDR_B0, w);
    expect_word(w, b, "operand b write");
    repeat (20) run_command(rand_operand(), rand_operand(), fpu_pkg::op_add);
    repeat (20) run_command(rand_operand(), rand_operand(), fpu_pkg::op_sub);
    a = rand_operand();
    run_command(a, a, fpu_pkg::op_sub);                                 // cancels to zero
    run_command(a, {~a.sign, a.exponent, a.mantissa}, fpu_pkg::op_add); // so does this
    repeat (15) run_command(rand_operand(), rand_operand(), fpu_pkg::op_mul);
    drain = 0;
    while (got_q.size() > 0 && drain < 10) begin
      @(posedge clk);
      drain++;
    end
    @(negedge clk);
    if (checked == pushed && checked > 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("only %0d of %0d read-backs were compared", checked, pushed);
      stop_on_fail();
    end
  end

  // overall guard against a stuck run
  initial begin : watchdog
    repeat (100000) @(posedge clk);
    $display("simulation ran too long without finishing");
    stop_on_fail();
  end

endmodule

// ==== fpu_top.f ====
+incdir+verilog
verilog/fpu_pkg.sv
verilog/fpu_op_if.sv
verilog/fpu_regs.sv
verilog/fpu_ctrl.sv
verilog/fpu_addsub.sv
verilog/fpu_mul.sv
verilog/fpu_top.sv
dv/fpu_assert.sv
dv/fpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the fpu testbench with Verilator, run it and check the log
verilator --binary --timing --assert -Wno-fatal --top-module fpu_tb -f fpu_top.f \
  -o fpu_sim > build.log 2>&1 || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/fpu_sim > sim.log 2>&1
grep -q "^>>> PASS$" sim.log && echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }
